/* files.f */
logic/router_pkg.sv
logic/route_fsm.sv
logic/egress_switch.sv
logic/egress_slice.sv
logic/route_counters.sv
logic/stream_router.sv
verif/tb_clock.sv
verif/stream_router_tb.sv

/* logic/egress_slice.sv */
`timescale 1ns/1ns

module egress_slice
  import router_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // Upstream side
  input  logic              in_valid,
  output logic              in_ready,
  input  logic [DATA_W-1:0] in_data,
  input  logic [KEEP_W-1:0] in_keep,
  input  logic              in_last,

  // Downstream side, driven straight from the main register
  output logic              out_valid,
  input  logic              out_ready,
  output logic [DATA_W-1:0] out_data,
  output logic [KEEP_W-1:0] out_keep,
  output logic              out_last
);

  logic              main_valid;
  logic [DATA_W-1:0] main_data;
  logic [KEEP_W-1:0] main_keep;
  logic              main_last;

  logic              spare_valid;
  logic [DATA_W-1:0] spare_data;
  logic [KEEP_W-1:0] spare_keep;
  logic              spare_last;

  logic              in_fire;
  logic              main_free;

  // Spare only fills when main is stalled, so this means both full
  assign in_ready  = ~spare_valid;
  assign in_fire   = in_valid && in_ready;
  assign main_free = ~main_valid || out_ready;

  // ------------------------------
  // Valid flags
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid  <= 1'b0;
      spare_valid <= 1'b0;
    end else if (main_free) begin
      main_valid  <= spare_valid || in_fire;
      spare_valid <= 1'b0;
    end else if (in_fire) begin
      spare_valid <= 1'b1;
    end
  end

  // ------------------------------
  // Payload
  // ------------------------------

  // Older beat in spare always goes out first
  always_ff @(posedge clk) begin
    if (main_free) begin
      if (spare_valid) begin
        main_data <= spare_data;
        main_keep <= spare_keep;
        main_last <= spare_last;
      end else if (in_fire) begin
        main_data <= in_data;
        main_keep <= in_keep;
        main_last <= in_last;
      end
    end else if (in_fire) begin
      spare_data <= in_data;
      spare_keep <= in_keep;
      spare_last <= in_last;
    end
  end

  assign out_valid = main_valid;
  assign out_data  = main_data;
  assign out_keep  = main_keep;
  assign out_last  = main_last;

endmodule

/* logic/egress_switch.sv */
`timescale 1ns/1ns

module egress_switch
  import router_pkg::*;
(
  input  route_sel_t        route,

  // Ingress
  input  logic              s_tvalid,
  output logic              s_tready,
  input  logic [DATA_W-1:0] s_tdata,
  input  logic [KEEP_W-1:0] s_tkeep,
  input  logic              s_tlast,

  // Egress 0 slice input
  output logic              e0_valid,
  input  logic              e0_ready,
  output logic [DATA_W-1:0] e0_data,
  output logic [KEEP_W-1:0] e0_keep,
  output logic              e0_last,

  // Egress 1 slice input
  output logic              e1_valid,
  input  logic              e1_ready,
  output logic [DATA_W-1:0] e1_data,
  output logic [KEEP_W-1:0] e1_keep,
  output logic              e1_last
);

  always_comb begin
    // Unselected egress sees an idle, zeroed bus
    s_tready = 1'b0;
    e0_valid = 1'b0;
    e0_data  = '0;
    e0_keep  = '0;
    e0_last  = 1'b0;
    e1_valid = 1'b0;
    e1_data  = '0;
    e1_keep  = '0;
    e1_last  = 1'b0;

    case (route)
      ROUTE_PORT0: begin
        s_tready = e0_ready;
        e0_valid = s_tvalid;
        e0_data  = s_tdata;
        e0_keep  = s_tkeep;
        e0_last  = s_tlast;
      end

      ROUTE_PORT1: begin
        s_tready = e1_ready;
        e1_valid = s_tvalid;
        e1_data  = s_tdata;
        e1_keep  = s_tkeep;
        e1_last  = s_tlast;
      end

      // Sink every beat of an unknown packet
      ROUTE_DROP: s_tready = 1'b1;

      default: s_tready = 1'b0;
    endcase
  end

endmodule

/* logic/route_counters.sv */
`timescale 1ns/1ns

module route_counters
  import router_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,

  // End of packet report from the FSM
  input  logic             pkt_done,
  input  route_sel_t       done_route,

  output logic [CNT_W-1:0] pkt_count0,
  output logic [CNT_W-1:0] pkt_count1,
  output logic [CNT_W-1:0] drop_count
);

  // Holds at all ones instead of wrapping
  function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] value);
    if (&value) begin
      return value;
    end
    return value + CNT_W'(1);
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pkt_count0 <= '0;
      pkt_count1 <= '0;
      drop_count <= '0;
    end else if (pkt_done) begin
      case (done_route)
        ROUTE_PORT0: pkt_count0 <= sat_inc(pkt_count0);
        ROUTE_PORT1: pkt_count1 <= sat_inc(pkt_count1);
        ROUTE_DROP:  drop_count <= sat_inc(drop_count);
        // ROUTE_NONE never finishes a packet
        default: ;
      endcase
    end
  end

endmodule

/* logic/route_fsm.sv */
`timescale 1ns/1ns

module route_fsm
  import router_pkg::*;
(
  input  logic             clk,
  input  logic             rst_n,

  // Ingress handshake, observed only
  input  logic             s_tvalid,
  input  logic             s_tready,
  input  logic             s_tlast,
  input  logic [TID_W-1:0] s_tid,

  // Destination of the packet in flight
  output route_sel_t       route,

  // End of packet report, one cycle after the last beat
  output logic             pkt_done,
  output route_sel_t       done_route
);

  enum logic [1:0] {
    IDLE,
    FORWARD,
    DROP
  } state;

  route_sel_t start_route;
  logic       last_fire;

  // ------------------------------
  // Packet start decode
  // ------------------------------

  // The ID is only looked at on the first beat
  always_comb begin
    if (s_tid == PORT0_TID) begin
      start_route = ROUTE_PORT0;
    end else if (s_tid == PORT1_TID) begin
      start_route = ROUTE_PORT1;
    end else begin
      start_route = ROUTE_DROP;
    end
  end

  assign last_fire = s_tvalid && s_tready && s_tlast;

  // ------------------------------
  // State and route registers
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      route      <= ROUTE_NONE;
      pkt_done   <= 1'b0;
      done_route <= ROUTE_NONE;
    end else begin
      pkt_done <= 1'b0;

      case (state)
        IDLE: begin
          // Route is registered, so the first beat moves next cycle
          if (s_tvalid) begin
            route <= start_route;
            if (start_route == ROUTE_DROP) begin
              state <= DROP;
            end else begin
              state <= FORWARD;
            end
          end
        end

        FORWARD, DROP: begin
          if (last_fire) begin
            state      <= IDLE;
            route      <= ROUTE_NONE;
            pkt_done   <= 1'b1;
            done_route <= route;
          end
        end

        default: begin
          state <= IDLE;
          route <= ROUTE_NONE;
        end
      endcase
    end
  end

endmodule

/* logic/router_pkg.sv */
package router_pkg;

  // ------------------------------
  // Stream widths
  // ------------------------------

  // Payload of one beat
  localparam int DATA_W = 32;

  // One keep bit per data byte
  localparam int KEEP_W = DATA_W / 8;

  localparam int TID_W = 4;

  // ------------------------------
  // Routing
  // ------------------------------

  // Stream IDs that select an egress, anything else is dropped
  localparam logic [TID_W-1:0] PORT0_TID = 4'h1;
  localparam logic [TID_W-1:0] PORT1_TID = 4'h2;

  // Width of each packet statistics counter
  localparam int CNT_W = 16;

  // Current destination of the ingress
  typedef enum logic [1:0] {
    ROUTE_NONE  = 2'd0,
    ROUTE_PORT0 = 2'd1,
    ROUTE_PORT1 = 2'd2,
    ROUTE_DROP  = 2'd3
  } route_sel_t;

endpackage

/* logic/stream_router.sv */
`timescale 1ns/1ns

module stream_router
  import router_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,

  // ------------------------------
  // Ingress
  // ------------------------------
  input  logic              s_tvalid,
  output logic              s_tready,
  input  logic [DATA_W-1:0] s_tdata,
  input  logic [KEEP_W-1:0] s_tkeep,
  input  logic              s_tlast,
  input  logic [TID_W-1:0]  s_tid,

  // ------------------------------
  // Egress 0 and 1
  // ------------------------------
  output logic              m0_tvalid,
  input  logic              m0_tready,
  output logic [DATA_W-1:0] m0_tdata,
  output logic [KEEP_W-1:0] m0_tkeep,
  output logic              m0_tlast,

  output logic              m1_tvalid,
  input  logic              m1_tready,
  output logic [DATA_W-1:0] m1_tdata,
  output logic [KEEP_W-1:0] m1_tkeep,
  output logic              m1_tlast,

  // Packet statistics
  output logic [CNT_W-1:0]  pkt_count0,
  output logic [CNT_W-1:0]  pkt_count1,
  output logic [CNT_W-1:0]  drop_count
);

  route_sel_t        route;
  route_sel_t        done_route;
  logic              pkt_done;

  // Switch to slice connections
  logic              e0_valid;
  logic              e0_ready;
  logic [DATA_W-1:0] e0_data;
  logic [KEEP_W-1:0] e0_keep;
  logic              e0_last;
  logic              e1_valid;
  logic              e1_ready;
  logic [DATA_W-1:0] e1_data;
  logic [KEEP_W-1:0] e1_keep;
  logic              e1_last;

  route_fsm u_route_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .s_tlast    (s_tlast),
    .s_tid      (s_tid),
    .route      (route),
    .pkt_done   (pkt_done),
    .done_route (done_route)
  );

  egress_switch u_egress_switch (
    .route    (route),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .s_tkeep  (s_tkeep),
    .s_tlast  (s_tlast),
    .e0_valid (e0_valid),
    .e0_ready (e0_ready),
    .e0_data  (e0_data),
    .e0_keep  (e0_keep),
    .e0_last  (e0_last),
    .e1_valid (e1_valid),
    .e1_ready (e1_ready),
    .e1_data  (e1_data),
    .e1_keep  (e1_keep),
    .e1_last  (e1_last)
  );

  egress_slice u_slice0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (e0_valid),
    .in_ready  (e0_ready),
    .in_data   (e0_data),
    .in_keep   (e0_keep),
    .in_last   (e0_last),
    .out_valid (m0_tvalid),
    .out_ready (m0_tready),
    .out_data  (m0_tdata),
    .out_keep  (m0_tkeep),
    .out_last  (m0_tlast)
  );

  egress_slice u_slice1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (e1_valid),
    .in_ready  (e1_ready),
    .in_data   (e1_data),
    .in_keep   (e1_keep),
    .in_last   (e1_last),
    .out_valid (m1_tvalid),
    .out_ready (m1_tready),
    .out_data  (m1_tdata),
    .out_keep  (m1_tkeep),
    .out_last  (m1_tlast)
  );

  route_counters u_route_counters (
    .clk        (clk),
    .rst_n      (rst_n),
    .pkt_done   (pkt_done),
    .done_route (done_route),
    .pkt_count0 (pkt_count0),
    .pkt_count1 (pkt_count1),
    .drop_count (drop_count)
  );

endmodule

/* run.sh */
#!/bin/sh
# Build and run the router testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module stream_router_tb -o sim_router
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_router)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

/* verif/stream_router_tb.sv */
`timescale 1ns/1ns

module stream_router_tb
  import router_pkg::*;
();

  localparam int BEAT_W = DATA_W + KEEP_W + 1;
  localparam int WAIT_LIMIT = 200;
  localparam int DRAIN_LIMIT = 2000;
  localparam int DEST_0 = 0;
  localparam int DEST_1 = 1;
  localparam int DEST_DROP = 2;

  logic              clk;
  logic              rst_n;
  logic              s_tvalid;
  logic              s_tready;
  logic [DATA_W-1:0] s_tdata;
  logic [KEEP_W-1:0] s_tkeep;
  logic              s_tlast;
  logic [TID_W-1:0]  s_tid;
  logic              m0_tvalid;
  logic              m0_tready;
  logic [DATA_W-1:0] m0_tdata;
  logic [KEEP_W-1:0] m0_tkeep;
  logic              m0_tlast;
  logic              m1_tvalid;
  logic              m1_tready;
  logic [DATA_W-1:0] m1_tdata;
  logic [KEEP_W-1:0] m1_tkeep;
  logic              m1_tlast;
  logic [CNT_W-1:0]  pkt_count0;
  logic [CNT_W-1:0]  pkt_count1;
  logic [CNT_W-1:0]  drop_count;

  int          seed;
  int          bp_seed;
  logic [31:0] bp_rand;
  logic        bp_en;
  logic        timed_out;
  int          err_count;
  int          cmp_errs;
  int          tests_run;
  int          exp_cnt [3];

  // Expected beats per egress, packed as {last, keep, data}
  logic [BEAT_W-1:0] exp_q0 [$];
  logic [BEAT_W-1:0] exp_q1 [$];

  tb_clock u_tb_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  stream_router u_stream_router (
    .clk        (clk),
    .rst_n      (rst_n),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .s_tdata    (s_tdata),
    .s_tkeep    (s_tkeep),
    .s_tlast    (s_tlast),
    .s_tid      (s_tid),
    .m0_tvalid  (m0_tvalid),
    .m0_tready  (m0_tready),
    .m0_tdata   (m0_tdata),
    .m0_tkeep   (m0_tkeep),
    .m0_tlast   (m0_tlast),
    .m1_tvalid  (m1_tvalid),
    .m1_tready  (m1_tready),
    .m1_tdata   (m1_tdata),
    .m1_tkeep   (m1_tkeep),
    .m1_tlast   (m1_tlast),
    .pkt_count0 (pkt_count0),
    .pkt_count1 (pkt_count1),
    .drop_count (drop_count)
  );

  // ------------------------------
  // Reference model
  // ------------------------------

  // Destination from the stream ID of the first beat
  function automatic int expected_dest(input logic [TID_W-1:0] tid);
    if (tid == PORT0_TID) begin
      return DEST_0;
    end
    if (tid == PORT1_TID) begin
      return DEST_1;
    end
    return DEST_DROP;
  endfunction

  function automatic int total_errors();
    return err_count + cmp_errs;
  endfunction

  // ------------------------------
  // Egress back-pressure
  // ------------------------------

  always @(posedge clk) begin
    if (bp_en) begin
      bp_rand = $random(bp_seed);
      m0_tready <= bp_rand[0];
      m1_tready <= bp_rand[1];
    end else begin
      m0_tready <= 1'b1;
      m1_tready <= 1'b1;
    end
  end

  // ------------------------------
  // Scoreboard
  // ------------------------------

  task automatic compare_beat(input int port, input logic [DATA_W-1:0] data,
                              input logic [KEEP_W-1:0] keep, input logic last);
    logic [BEAT_W-1:0] exp;
    int                depth;
    depth = (port == 0) ? exp_q0.size() : exp_q1.size();
    assert (depth != 0) else begin
      $display("Egress %0d transferred a beat that no packet sent to it", port);
      cmp_errs++;
    end
    if (depth == 0) begin
      return;
    end
    exp = (port == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
    assert (data == exp[DATA_W-1:0]) else begin
      $display("Fail m%0d_tdata: expected %h, got %h", port, exp[DATA_W-1:0], data);
      cmp_errs++;
    end
    assert (keep == exp[DATA_W +: KEEP_W]) else begin
      $display("Fail m%0d_tkeep: expected %h, got %h", port, exp[DATA_W +: KEEP_W], keep);
      cmp_errs++;
    end
    assert (last == exp[BEAT_W-1]) else begin
      $display("Fail m%0d_tlast: expected %h, got %h", port, exp[BEAT_W-1], last);
      cmp_errs++;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      if (m0_tvalid && m0_tready) begin
        compare_beat(0, m0_tdata, m0_tkeep, m0_tlast);
      end
      if (m1_tvalid && m1_tready) begin
        compare_beat(1, m1_tdata, m1_tkeep, m1_tlast);
      end
    end
  end

  // ------------------------------
  // Stimulus tasks
  // ------------------------------

  task automatic wait_reset();
    int waited;
    waited = 0;
    while (!rst_n && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (!rst_n) begin
      $display("Reset was never released");
      timed_out = 1'b1;
      err_count++;
    end
    @(posedge clk);
  endtask

  task automatic send_packet(input logic [TID_W-1:0] tid, input int len);
    int          dest;
    int          waited;
    logic [31:0] r;
    logic [BEAT_W-1:0] beat_word;
    dest = expected_dest(tid);
    if (timed_out) begin
      return;
    end
    @(posedge clk);
    for (int beat = 0; beat < len; beat++) begin
      r = $random(seed);
      beat_word[DATA_W-1:0] = r;
      r = $random(seed);
      beat_word[DATA_W +: KEEP_W] = r[KEEP_W-1:0];
      beat_word[BEAT_W-1] = (beat == len - 1);
      s_tvalid <= 1'b1;
      s_tdata  <= beat_word[DATA_W-1:0];
      s_tkeep  <= beat_word[DATA_W +: KEEP_W];
      s_tlast  <= beat_word[BEAT_W-1];
      s_tid    <= tid;
      if (dest == DEST_0) begin
        exp_q0.push_back(beat_word);
      end else if (dest == DEST_1) begin
        exp_q1.push_back(beat_word);
      end
      // Transfer happens on the first edge that sees s_tready high
      waited = 0;
      @(posedge clk);
      while (!s_tready && waited < WAIT_LIMIT) begin
        @(posedge clk);
        waited++;
      end
      if (!s_tready) begin
        $display("Ingress never accepted beat %0d of a packet with tid %h", beat, tid);
        timed_out = 1'b1;
        err_count++;
        s_tvalid <= 1'b0;
        return;
      end
    end
    s_tvalid <= 1'b0;
    s_tlast  <= 1'b0;
    exp_cnt[dest]++;
  endtask

  task automatic drain();
    int waited;
    if (timed_out) begin
      return;
    end
    waited = 0;
    while ((exp_q0.size() != 0 || exp_q1.size() != 0 || m0_tvalid || m1_tvalid)
           && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (waited >= DRAIN_LIMIT) begin
      $display("Egress traffic did not drain, %0d and %0d beats still expected",
               exp_q0.size(), exp_q1.size());
      timed_out = 1'b1;
      err_count++;
    end
    // pkt_done one cycle after the last beat, counter one cycle later
    repeat (3) @(posedge clk);
  endtask

  task automatic check_counts();
    assert (pkt_count0 == CNT_W'(exp_cnt[DEST_0])) else begin
      $display("Fail pkt_count0: expected %h, got %h", CNT_W'(exp_cnt[DEST_0]), pkt_count0);
      err_count++;
    end
    assert (pkt_count1 == CNT_W'(exp_cnt[DEST_1])) else begin
      $display("Fail pkt_count1: expected %h, got %h", CNT_W'(exp_cnt[DEST_1]), pkt_count1);
      err_count++;
    end
    assert (drop_count == CNT_W'(exp_cnt[DEST_DROP])) else begin
      $display("Fail drop_count: expected %h, got %h", CNT_W'(exp_cnt[DEST_DROP]), drop_count);
      err_count++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    $display("Test %0d %s done, %0d errors", tests_run, name, total_errors() - errs_before);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    int          errs_before;
    logic [31:0] r;
    logic [TID_W-1:0] tid;
    seed = 32'he9cb;
    bp_seed = $random(seed);
    bp_en = 1'b0;
    timed_out = 1'b0;
    err_count = 0;
    cmp_errs = 0;
    tests_run = 0;
    for (int i = 0; i < 3; i++) begin
      exp_cnt[i] = 0;
    end
    s_tvalid  = 1'b0;
    s_tdata   = '0;
    s_tkeep   = '0;
    s_tlast   = 1'b0;
    s_tid     = '0;
    m0_tready = 1'b0;
    m1_tready = 1'b0;

    // Idle outputs right after reset
    errs_before = total_errors();
    wait_reset();
    assert (s_tready == 1'b0) else begin
      $display("Fail s_tready: expected 0, got %h", s_tready);
      err_count++;
    end
    assert (m0_tvalid == 1'b0 && m1_tvalid == 1'b0) else begin
      $display("Fail m0_tvalid/m1_tvalid: expected 0/0, got %h/%h", m0_tvalid, m1_tvalid);
      err_count++;
    end
    check_counts();
    end_test("reset state", errs_before);

    errs_before = total_errors();
    for (int i = 0; i < 8; i++) begin
      r = $random(seed);
      send_packet((i < 4) ? PORT0_TID : PORT1_TID, int'(r[2:0]) + 1);
    end
    drain();
    check_counts();
    end_test("known ID routing", errs_before);

    // Unknown IDs, moved off 1 and 2 when they collide
    errs_before = total_errors();
    for (int i = 0; i < 5; i++) begin
      r = $random(seed);
      tid = r[TID_W-1:0];
      if (tid == PORT0_TID || tid == PORT1_TID) begin
        tid = tid + TID_W'(4);
      end
      send_packet(tid, int'(r[6:4]) + 1);
      drain();
      check_counts();
    end
    end_test("dropped packets", errs_before);

    errs_before = total_errors();
    bp_en = 1'b1;
    for (int i = 0; i < 30; i++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0:    tid = PORT0_TID;
        2'd1:    tid = PORT1_TID;
        default: tid = r[7:4];
      endcase
      send_packet(tid, int'(r[10:8]) + 1);
    end
    drain();
    end_test("mixed traffic with back-pressure", errs_before);

    errs_before = total_errors();
    bp_en = 1'b0;
    drain();
    check_counts();
    assert (exp_q0.size() == 0 && exp_q1.size() == 0) else begin
      $display("Beats were sent but never came out of an egress");
      err_count++;
    end
    end_test("final statistics", errs_before);

    $display("Tests run: %0d, errors: %0d", tests_run, total_errors());
    if (total_errors() == 0 && !timed_out) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 20;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Release on a rising edge, like any other driven input
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule
